// ==== verilog.f ====
verilog/ctrl_pkg.sv
verilog/id_stage.sv
verilog/id_decode.sv
verilog/stage_reg.sv
verilog/operand_forward.sv
verilog/branch_status.sv
verilog/ctrl_top.sv
tb/ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the control block testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ctrl_tb -f verilog.f -o ctrl_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/ctrl_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
	exit 0
fi
exit 1

// ==== tb/ctrl_tb.sv ====
`timescale 1ns/1ns

module ctrl_tb;
	import ctrl_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_COUNT = 400;
	localparam int DIRECTED_COUNT = 14;
	// four times the scripted run
	localparam int CYCLE_LIMIT = 4 * (RESET_CYCLES + RANDOM_COUNT + DIRECTED_COUNT);

	// legal opcodes, then mac, fpu, custom and unused codes
	localparam logic [5:0] OPCODES [35] = '{
		6'h00, 6'h01, 6'h03, 6'h04, 6'h05, 6'h06, 6'h08, 6'h09,
		6'h11, 6'h12, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26,
		6'h27, 6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2c, 6'h2d, 6'h2e,
		6'h2f, 6'h30, 6'h35, 6'h36, 6'h37, 6'h38, 6'h39,
		6'h13, 6'h32, 6'h3c, 6'h0a
	};

	// expected EX controls, built from the decode rules
	typedef struct packed {
		logic [31:0] insn;
		logic [2:0]  br;
		logic [4:0]  alu;
		logic [3:0]  alu2;
		logic [3:0]  cmp;
		logic [3:0]  rfwb;
		logic [4:0]  addrw;
		logic [31:0] simm;
		logic [29:0] tgt;
		logic        spr_rd;
		logic        spr_wr;
		logic        ill;
		logic        sys;
		logic        trp;
	} exp_t;

	localparam exp_t EXP_BUBBLE = '{insn: 32'h1541_0000, alu: 5'd15, default: '0};

	logic clk, rst;
	logic [31:0] if_insn, id_pc;
	logic id_freeze, ex_freeze, wb_freeze;
	logic except_flushpipe, extend_flush, pc_we, du_flush_pipe;
	logic ex_branch_taken, wbforw_valid, du_hwbkpt, abort_mvspr;
	logic flushpipe, rf_rda, rf_rdb, except_illegal, sig_syscall, sig_trap;
	logic ex_spr_read, ex_spr_write, id_void, ex_void, no_more_dslot, rfe;
	logic ex_dslot_dsi, ex_dslot_nop;
	logic [31:0] id_insn, ex_insn, wb_insn, id_simm, ex_simm;
	logic [31:2] ex_branch_addrtarget;
	logic [3:0] alu_op2, comp_op;
	branch_op_e id_branch_op, ex_branch_op;
	reg_addr_t rf_addra, rf_addrb, rf_addrw;
	rfwb_op_t rfwb_op;
	alu_op_e alu_op;
	sel_e sel_a, sel_b;
	lsu_op_e id_lsu_op;

	// reference pipeline state
	logic [31:0] exp_id;
	exp_t exp_ex;
	logic [31:0] exp_wb;
	logic [4:0] exp_wb_addrw;
	logic exp_dsi, exp_nop;
	integer seed = 39328;
	integer cycles;

	// reference values that follow from the current state
	logic flush_any;
	exp_t exp_idd;
	logic [1:0] exp_sel_a, exp_sel_b;
	logic exp_rfe, exp_no_more;

	ctrl_top ctrl_top_i (.*);

	function automatic exp_t decode(logic [31:0] i, logic [31:0] pc, logic hw);
		exp_t e;
		logic [31:0] s16;
		e = EXP_BUBBLE;
		s16 = {{16{i[15]}}, i[15:0]};
		e.insn = i;
		e.alu2 = i[9:6];
		e.cmp = i[24:21];
		e.addrw = i[25:21];
		e.simm = {16'b0, i[15:0]};
		e.tgt = {{4{i[25]}}, i[25:0]} + pc[31:2];
		e.spr_rd = (i[31:26] == 6'h2d);
		e.spr_wr = (i[31:26] == 6'h30);
		e.sys = (i[31:23] == 9'b001000_000);
		e.trp = (i[31:23] == 9'b001000_010) || hw;
		case (i[31:26])
			6'h00, 6'h01: e.br = 3'd1;
			6'h11, 6'h12: e.br = 3'd2;
			6'h03: e.br = 3'd3;
			6'h04: e.br = 3'd4;
			6'h09: e.br = 3'd5;
			default: e.br = 3'd0;
		endcase
		case (i[31:26])
			6'h00, 6'h03, 6'h04, 6'h05, 6'h08, 6'h09, 6'h11: e.ill = 1'b0;
			6'h01, 6'h12: begin
				e.rfwb = {3'd1, 1'b1};
				e.addrw = 5'd9;
			end
			6'h06: begin
				e.alu = 5'd12;
				e.rfwb = 4'b0001;
			end
			6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26: begin
				e.simm = s16;
				e.rfwb = {3'd3, 1'b1};
			end
			6'h2d: e.rfwb = {3'd2, 1'b1};
			6'h30: e.simm = {16'b0, i[25:21], i[10:0]};
			6'h35, 6'h36, 6'h37: e.simm = {{16{i[25]}}, i[25:21], i[10:0]};
			6'h27, 6'h28, 6'h2b, 6'h2c: begin
				e.simm = s16;
				e.rfwb = 4'b0001;
				case (i[31:26])
					6'h27: e.alu = 5'd0;
					6'h28: e.alu = 5'd1;
					6'h2b: e.alu = 5'd5;
					default: e.alu = 5'd6;
				endcase
			end
			6'h29, 6'h2a, 6'h2e: begin
				e.rfwb = 4'b0001;
				e.alu = (i[31:26] == 6'h29) ? 5'd3 : (i[31:26] == 6'h2a) ? 5'd4 : 5'd8;
			end
			6'h2f: begin
				e.simm = s16;
				e.alu = 5'd13;
			end
			6'h39: e.alu = 5'd13;
			6'h38: begin
				e.alu = {1'b0, i[3:0]};
				e.rfwb = 4'b0001;
				// no divider in this core
				e.ill = (i[4:0] == 5'd9) || (i[4:0] == 5'd10);
			end
			default: e.ill = 1'b1;
		endcase
		return e;
	endfunction

	function automatic logic [3:0] lsu_of(logic [31:0] i);
		case (i[31:26])
			6'h21: return 4'd6;
			6'h22: return 4'd7;
			6'h23: return 4'd2;
			6'h24: return 4'd3;
			6'h25: return 4'd4;
			6'h26: return 4'd5;
			6'h35: return 4'd12;
			6'h36: return 4'd8;
			6'h37: return 4'd10;
			default: return 4'd0;
		endcase
	endfunction

	function automatic logic imm_of(logic [31:0] i);
		case (i[31:26])
			6'h12, 6'h11, 6'h09, 6'h2d, 6'h30, 6'h08,
			6'h35, 6'h36, 6'h37, 6'h38, 6'h39, 6'h05: return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	// EX producer first, then WB
	function automatic logic [1:0] src_sel(logic [4:0] a, logic [4:0] ex_a, logic ex_we,
		logic [4:0] wb_a, logic wb_ok);
		if ((a == ex_a) && ex_we)
			return 2'd2;
		else if ((a == wb_a) && wb_ok)
			return 2'd3;
		return 2'd0;
	endfunction

	function automatic logic void_of(logic [31:0] i);
		return (i[31:26] == 6'h05) && i[16];
	endfunction

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
		$display("[FAIL] %s got %h expected %h", name, got, want);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference pipeline

	assign flush_any = except_flushpipe | extend_flush | pc_we | du_flush_pipe;

	always_comb begin
		exp_idd = decode(exp_id, id_pc, du_hwbkpt);
		exp_sel_a = src_sel(exp_id[20:16], exp_ex.addrw, exp_ex.rfwb[0],
			exp_wb_addrw, wbforw_valid);
		exp_sel_b = imm_of(exp_id) ? 2'd1 : src_sel(exp_id[15:11], exp_ex.addrw,
			exp_ex.rfwb[0], exp_wb_addrw, wbforw_valid);
		exp_rfe = (exp_ex.br == 3'd5) || (exp_idd.br == 3'd5);
		exp_no_more = (exp_ex.br != 0 && ex_branch_taken && !void_of(exp_id)) ||
			(exp_ex.br == 3'd5);
	end

	always @(posedge clk) begin
		if (rst) begin
			exp_id <= NOP_INSN;
			exp_ex <= EXP_BUBBLE;
			exp_wb <= NOP_INSN;
			exp_wb_addrw <= '0;
			exp_dsi <= 1'b0;
			exp_nop <= 1'b0;
		end else begin
			if (flush_any)
				exp_id <= NOP_INSN;
			else if (!id_freeze)
				exp_id <= if_insn;
			if (flush_any || (!ex_freeze && id_freeze))
				exp_ex <= EXP_BUBBLE;
			else if (!ex_freeze)
				exp_ex <= exp_idd;
			if (!wb_freeze) begin
				exp_wb <= exp_ex.insn;
				exp_wb_addrw <= exp_ex.addrw;
			end
			if (!ex_freeze) begin
				if (exp_nop) begin
					exp_nop <= void_of(exp_id);
					exp_dsi <= !void_of(exp_id);
				end else if (exp_dsi) begin
					exp_dsi <= 1'b0;
				end else begin
					exp_nop <= ex_branch_taken && exp_ex.br != 0 && exp_ex.br != 5 &&
						void_of(exp_id);
					exp_dsi <= ex_branch_taken && exp_ex.br != 0 && exp_ex.br != 5 &&
						!void_of(exp_id);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks

	assert property (@(posedge clk) disable iff (rst) flushpipe == flush_any)
		else report_mismatch("flushpipe", 32'($sampled(flushpipe)), 32'($sampled(flush_any)));
	assert property (@(posedge clk) disable iff (rst) id_insn == exp_id)
		else report_mismatch("id_insn", $sampled(id_insn), $sampled(exp_id));
	assert property (@(posedge clk) disable iff (rst) ex_insn == exp_ex.insn)
		else report_mismatch("ex_insn", $sampled(ex_insn), $sampled(exp_ex.insn));
	assert property (@(posedge clk) disable iff (rst) wb_insn == exp_wb)
		else report_mismatch("wb_insn", $sampled(wb_insn), $sampled(exp_wb));
	assert property (@(posedge clk) disable iff (rst) id_branch_op == exp_idd.br)
		else report_mismatch("id_branch_op", 32'($sampled(id_branch_op)),
			32'($sampled(exp_idd.br)));
	assert property (@(posedge clk) disable iff (rst)
		{rf_addra, rf_addrb} == {if_insn[20:16], if_insn[15:11]})
		else report_mismatch("rf_addra_rf_addrb", 32'($sampled({rf_addra, rf_addrb})),
			32'($sampled({if_insn[20:16], if_insn[15:11]})));
	assert property (@(posedge clk) disable iff (rst) {rf_rda, rf_rdb} == if_insn[31:30])
		else report_mismatch("rf_rda_rf_rdb", 32'($sampled({rf_rda, rf_rdb})),
			32'($sampled(if_insn[31:30])));
	assert property (@(posedge clk) disable iff (rst)
		{id_void, ex_void} == {void_of(exp_id), void_of(exp_ex.insn)})
		else report_mismatch("id_void_ex_void", 32'($sampled({id_void, ex_void})),
			32'({void_of($sampled(exp_id)), void_of($sampled(exp_ex.insn))}));
	assert property (@(posedge clk) disable iff (rst) alu_op == exp_ex.alu)
		else report_mismatch("alu_op", 32'($sampled(alu_op)), 32'($sampled(exp_ex.alu)));
	assert property (@(posedge clk) disable iff (rst) rfwb_op == exp_ex.rfwb)
		else report_mismatch("rfwb_op", 32'($sampled(rfwb_op)), 32'($sampled(exp_ex.rfwb)));
	assert property (@(posedge clk) disable iff (rst) rf_addrw == exp_ex.addrw)
		else report_mismatch("rf_addrw", 32'($sampled(rf_addrw)), 32'($sampled(exp_ex.addrw)));
	assert property (@(posedge clk) disable iff (rst) ex_simm == exp_ex.simm)
		else report_mismatch("ex_simm", $sampled(ex_simm), $sampled(exp_ex.simm));
	assert property (@(posedge clk) disable iff (rst) ex_branch_addrtarget == exp_ex.tgt)
		else report_mismatch("ex_branch_addrtarget", 32'($sampled(ex_branch_addrtarget)),
			32'($sampled(exp_ex.tgt)));
	assert property (@(posedge clk) disable iff (rst)
		{except_illegal, sig_syscall, sig_trap} == {exp_ex.ill, exp_ex.sys, exp_ex.trp})
		else report_mismatch("illegal_syscall_trap",
			32'($sampled({except_illegal, sig_syscall, sig_trap})),
			32'($sampled({exp_ex.ill, exp_ex.sys, exp_ex.trp})));
	assert property (@(posedge clk) disable iff (rst)
		{ex_spr_read, ex_spr_write} == ({exp_ex.spr_rd, exp_ex.spr_wr} & {2{!abort_mvspr}}))
		else report_mismatch("ex_spr_read_write", 32'($sampled({ex_spr_read, ex_spr_write})),
			32'($sampled({exp_ex.spr_rd, exp_ex.spr_wr} & {2{!abort_mvspr}})));
	assert property (@(posedge clk) disable iff (rst)
		{alu_op2, comp_op, ex_branch_op} == {exp_ex.alu2, exp_ex.cmp, exp_ex.br})
		else report_mismatch("alu_op2_comp_op_ex_branch_op",
			32'($sampled({alu_op2, comp_op, ex_branch_op})),
			32'($sampled({exp_ex.alu2, exp_ex.cmp, exp_ex.br})));
	assert property (@(posedge clk) disable iff (rst) id_lsu_op == lsu_of(exp_id))
		else report_mismatch("id_lsu_op", 32'($sampled(id_lsu_op)), 32'(lsu_of($sampled(exp_id))));
	assert property (@(posedge clk) disable iff (rst) id_simm == exp_idd.simm)
		else report_mismatch("id_simm", $sampled(id_simm), $sampled(exp_idd.simm));
	assert property (@(posedge clk) disable iff (rst)
		{sel_a, sel_b} == {exp_sel_a, exp_sel_b})
		else report_mismatch("sel_a_sel_b", 32'($sampled({sel_a, sel_b})),
			32'($sampled({exp_sel_a, exp_sel_b})));
	assert property (@(posedge clk) disable iff (rst)
		{ex_dslot_dsi, ex_dslot_nop} == {exp_dsi, exp_nop})
		else report_mismatch("ex_dslot_dsi_nop", 32'($sampled({ex_dslot_dsi, ex_dslot_nop})),
			32'($sampled({exp_dsi, exp_nop})));
	assert property (@(posedge clk) disable iff (rst)
		{rfe, no_more_dslot} == {exp_rfe, exp_no_more})
		else report_mismatch("rfe_no_more_dslot", 32'($sampled({rfe, no_more_dslot})),
			32'($sampled({exp_rfe, exp_no_more})));

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run exceeded the cycle limit without finishing");
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus

	task automatic drive_insn(logic [31:0] word, logic taken);
		@(negedge clk);
		if_insn = word;
		ex_branch_taken = taken;
		{id_freeze, ex_freeze, wb_freeze} = 3'b000;
		{except_flushpipe, extend_flush, pc_we, du_flush_pipe} = 4'b0000;
	endtask

	task automatic drive_random();
		logic [31:0] r;
		@(negedge clk);
		r = $random(seed);
		if_insn = (r[31:29] == 3'd0) ? NOP_INSN : {OPCODES[r[5:0] % 35], r[31:6]};
		r = $random(seed);
		id_freeze = r[2:0] == 0;
		ex_freeze = r[5:3] == 0;
		wb_freeze = r[8:6] == 0;
		except_flushpipe = r[12:9] == 0;
		extend_flush = r[16:13] == 0;
		pc_we = r[20:17] == 0;
		du_flush_pipe = r[24:21] == 0;
		ex_branch_taken = r[25];
		wbforw_valid = r[26];
		du_hwbkpt = r[30:27] == 0;
		abort_mvspr = r[31] && r[0];
		id_pc = {$random(seed)} & 32'hffff_fffc;
	endtask

	initial begin
		cycles = 0;
		rst = 1'b1;
		if_insn = NOP_INSN;
		id_pc = 32'h0000_1000;
		{id_freeze, ex_freeze, wb_freeze} = 3'b000;
		{except_flushpipe, extend_flush, pc_we, du_flush_pipe} = 4'b0000;
		{ex_branch_taken, wbforw_valid, du_hwbkpt, abort_mvspr} = 4'b0000;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (RANDOM_COUNT) drive_random();
		du_hwbkpt = 1'b0;
		abort_mvspr = 1'b0;
		// dependent pair, r3 produced then consumed
		drive_insn({6'h27, 5'd3, 5'd1, 16'h0010}, 1'b0);
		drive_insn({6'h38, 5'd4, 5'd3, 5'd3, 11'h000}, 1'b0);
		drive_insn(NOP_INSN, 1'b0);
		// taken is seen while the branch sits in EX, two drives after it
		drive_insn({6'h04, 26'h0000040}, 1'b0);
		drive_insn({6'h29, 5'd5, 5'd6, 16'h00ff}, 1'b0);
		// first branch taken with a real slot in ID
		drive_insn({6'h04, 26'h3ffffc0}, 1'b1);
		drive_insn(NOP_INSN, 1'b0);
		// second branch taken with a filler in ID
		drive_insn(NOP_INSN, 1'b1);
		drive_insn({6'h09, 26'h0}, 1'b0);
		repeat (4) drive_insn(NOP_INSN, 1'b0);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== verilog/ctrl_top.sv ====
`timescale 1ns/1ns

module ctrl_top #(
	parameter bit IMPL_MUL = 1'b1
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [31:0]           if_insn,
	input  logic [31:0]           id_pc,
	input  logic                  id_freeze,
	input  logic                  ex_freeze,
	input  logic                  wb_freeze,
	input  logic                  except_flushpipe,
	input  logic                  extend_flush,
	input  logic                  pc_we,
	input  logic                  du_flush_pipe,
	input  logic                  ex_branch_taken,
	input  logic                  wbforw_valid,
	input  logic                  du_hwbkpt,
	input  logic                  abort_mvspr,
	output logic                  flushpipe,
	output logic [31:0]           id_insn,
	output logic [31:0]           ex_insn,
	output logic [31:0]           wb_insn,
	output ctrl_pkg::branch_op_e  id_branch_op,
	output ctrl_pkg::branch_op_e  ex_branch_op,
	output logic [31:2]           ex_branch_addrtarget,
	output ctrl_pkg::reg_addr_t   rf_addra,
	output ctrl_pkg::reg_addr_t   rf_addrb,
	output logic                  rf_rda,
	output logic                  rf_rdb,
	output ctrl_pkg::reg_addr_t   rf_addrw,
	output ctrl_pkg::rfwb_op_t    rfwb_op,
	output ctrl_pkg::alu_op_e     alu_op,
	output logic [3:0]            alu_op2,
	output logic [3:0]            comp_op,
	output logic [31:0]           id_simm,
	output logic [31:0]           ex_simm,
	output ctrl_pkg::sel_e        sel_a,
	output ctrl_pkg::sel_e        sel_b,
	output ctrl_pkg::lsu_op_e     id_lsu_op,
	output logic                  except_illegal,
	output logic                  sig_syscall,
	output logic                  sig_trap,
	output logic                  ex_spr_read,
	output logic                  ex_spr_write,
	output logic                  id_void,
	output logic                  ex_void,
	output logic                  no_more_dslot,
	output logic                  rfe,
	output logic                  ex_dslot_dsi,
	output logic                  ex_dslot_nop
);
	import ctrl_pkg::*;

	ex_ctrl_t id_ctrl;
	ex_ctrl_t ex_ctrl;
	wb_ctrl_t wb_d;
	wb_ctrl_t wb_ctrl;
	logic     sel_imm;

	////////////////////////////////////////////////////////////////////////////
	// IF -> ID, decode

	id_stage id_stage_i (
		.clk, .rst, .if_insn, .id_freeze,
		.except_flushpipe, .extend_flush, .pc_we, .du_flush_pipe,
		.flushpipe, .id_insn, .id_branch_op, .sel_imm,
		.rf_addra, .rf_addrb, .rf_rda, .rf_rdb
	);

	id_decode #(.IMPL_MUL(IMPL_MUL)) id_decode_i (
		.id_insn, .id_pc, .du_hwbkpt, .id_ctrl, .id_lsu_op, .id_void
	);

	assign id_simm = id_ctrl.simm;

	// forwarding compares against the destinations one and two stages ahead
	operand_forward operand_forward_i (
		.id_insn, .sel_imm,
		.ex_rf_addrw(ex_ctrl.rf_addrw), .ex_rf_we(ex_ctrl.rfwb_op.we),
		.wb_rf_addrw(wb_ctrl.rf_addrw), .wbforw_valid,
		.sel_a, .sel_b
	);

	////////////////////////////////////////////////////////////////////////////
	// ID -> EX -> WB

	stage_reg #(.payload_t(ex_ctrl_t), .BUBBLE(EX_BUBBLE)) ex_reg (
		.clk, .rst, .freeze(ex_freeze), .upstream_freeze(id_freeze),
		.flush(flushpipe), .d(id_ctrl), .q(ex_ctrl)
	);

	// WB keeps the insn through exceptions, no flush here
	assign wb_d = '{insn: ex_ctrl.insn, rf_addrw: ex_ctrl.rf_addrw};

	stage_reg #(.payload_t(wb_ctrl_t), .BUBBLE(WB_RESET)) wb_reg (
		.clk, .rst, .freeze(wb_freeze), .upstream_freeze(1'b0),
		.flush(1'b0), .d(wb_d), .q(wb_ctrl)
	);

	branch_status branch_status_i (
		.clk, .rst, .ex_freeze, .id_void, .id_branch_op,
		.ex_branch_op(ex_ctrl.branch_op), .ex_branch_taken,
		.no_more_dslot, .rfe, .ex_dslot_dsi, .ex_dslot_nop
	);

	// EX outputs
	assign ex_insn = ex_ctrl.insn;
	assign ex_branch_op = ex_ctrl.branch_op;
	assign ex_branch_addrtarget = ex_ctrl.branch_target;
	assign rf_addrw = ex_ctrl.rf_addrw;
	assign rfwb_op = ex_ctrl.rfwb_op;
	assign alu_op = ex_ctrl.alu_op;
	assign alu_op2 = ex_ctrl.alu_op2;
	assign comp_op = ex_ctrl.comp_op;
	assign ex_simm = ex_ctrl.simm;
	assign except_illegal = ex_ctrl.illegal;
	assign sig_syscall = ex_ctrl.syscall;
	assign sig_trap = ex_ctrl.trap;
	assign ex_void = is_void(ex_ctrl.insn);
	// aborted move to/from spr must not touch the spr bus
	assign ex_spr_read = ex_ctrl.spr_read && !abort_mvspr;
	assign ex_spr_write = ex_ctrl.spr_write && !abort_mvspr;

	assign wb_insn = wb_ctrl.insn;

endmodule

// ==== verilog/branch_status.sv ====
`timescale 1ns/1ns

module branch_status (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ex_freeze,
	input  logic                  id_void,
	input  ctrl_pkg::branch_op_e  id_branch_op,
	input  ctrl_pkg::branch_op_e  ex_branch_op,
	input  logic                  ex_branch_taken,
	output logic                  no_more_dslot,
	output logic                  rfe,
	output logic                  ex_dslot_dsi,
	output logic                  ex_dslot_nop
);
	import ctrl_pkg::*;

	logic jump_taken;

	// real jump or branch resolved taken, rfe has no delay slot
	assign jump_taken = ex_branch_taken && (ex_branch_op != BR_NOP) &&
		(ex_branch_op != BR_RFE);

	////////////////////////////////////////////////////////////////////////////
	// delay slot tracker
	// dsi  delay slot insn sits in EX
	// nop  filler nop in EX, delay slot insn still to come

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_dslot_dsi <= 1'b0;
			ex_dslot_nop <= 1'b0;
		end else if (!ex_freeze) begin
			if (ex_dslot_nop && !ex_dslot_dsi) begin
				// waiting on the slot, it arrives once ID is real
				ex_dslot_nop <= id_void;
				ex_dslot_dsi <= !id_void;
			end else if (ex_dslot_dsi && !ex_dslot_nop) begin
				ex_dslot_nop <= 1'b0;
				ex_dslot_dsi <= 1'b0;
			end else begin
				ex_dslot_nop <= jump_taken && id_void;
				ex_dslot_dsi <= jump_taken && !id_void;
			end
		end
	end

	// slot already fetched, front end must not fetch another
	assign no_more_dslot = (ex_branch_op != BR_NOP && ex_branch_taken && !id_void) ||
		(ex_branch_op == BR_RFE);

	assign rfe = (id_branch_op == BR_RFE) || (ex_branch_op == BR_RFE);

	// delay slot occupies EX for one advance only
	assert property (@(posedge clk) disable iff (rst)
		(ex_dslot_dsi && !ex_dslot_nop && !ex_freeze) |=> (!ex_dslot_dsi && !ex_dslot_nop));

endmodule

// ==== verilog/operand_forward.sv ====
`timescale 1ns/1ns

module operand_forward (
	input  logic [31:0]          id_insn,
	input  logic                 sel_imm,
	input  ctrl_pkg::reg_addr_t  ex_rf_addrw,
	input  logic                 ex_rf_we,
	input  ctrl_pkg::reg_addr_t  wb_rf_addrw,
	input  logic                 wbforw_valid,
	output ctrl_pkg::sel_e       sel_a,
	output ctrl_pkg::sel_e       sel_b
);
	import ctrl_pkg::*;

	// youngest producer wins, EX before WB
	function automatic sel_e fwd_sel(reg_addr_t src);
		if ((src == ex_rf_addrw) && ex_rf_we)
			return SEL_EX_FORW;
		else if ((src == wb_rf_addrw) && wbforw_valid)
			return SEL_WB_FORW;
		else
			return SEL_RF;
	endfunction

	assign sel_a = fwd_sel(id_insn[20:16]);

	// immediate overrides any hazard on rB
	assign sel_b = sel_imm ? SEL_IMM : fwd_sel(id_insn[15:11]);

endmodule

// ==== verilog/stage_reg.sv ====
`timescale 1ns/1ns

module stage_reg #(
	parameter type payload_t = logic [31:0],
	parameter payload_t BUBBLE = '0
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     freeze,
	input  logic     upstream_freeze,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	logic bubble;

	// stage moves on but upstream is stuck, so a hole enters
	assign bubble = flush || (!freeze && upstream_freeze);

	always_ff @(posedge clk) begin
		if (rst || bubble) begin
			q <= BUBBLE;
		end else if (!freeze) begin
			q <= d;
		end
	end

	// no payload survives a bubble cycle
	assert property (@(posedge clk) disable iff (rst)
		bubble |=> (q == BUBBLE));

endmodule

// ==== verilog/id_decode.sv ====
`timescale 1ns/1ns

module id_decode #(
	parameter bit IMPL_MUL = 1'b1
) (
	input  logic [31:0]         id_insn,
	input  logic [31:0]         id_pc,
	input  logic                du_hwbkpt,
	output ctrl_pkg::ex_ctrl_t  id_ctrl,
	output ctrl_pkg::lsu_op_e   id_lsu_op,
	output logic                id_void
);
	import ctrl_pkg::*;

	localparam rfwb_op_t WB_ALU = '{src: RFWB_ALU, we: 1'b1};

	opcode_e     op;
	logic [4:0]  alu_fn;
	logic [31:0] sext16;
	logic        mul_fn;
	logic        div_fn;

	assign op = opcode_e'(id_insn[31:26]);
	assign alu_fn = id_insn[4:0];
	assign sext16 = {{16{id_insn[15]}}, id_insn[15:0]};
	// register-register mul/div functions
	assign mul_fn = (alu_fn == ALU_MUL) || (alu_fn == ALU_MULU);
	assign div_fn = (alu_fn == ALU_DIV) || (alu_fn == ALU_DIVU);

	assign id_void = is_void(id_insn);

	////////////////////////////////////////////////////////////////////////////
	// EX control word

	always_comb begin
		id_ctrl = EX_BUBBLE;
		id_ctrl.insn = id_insn;
		id_ctrl.branch_op = branch_op_of(id_insn);
		id_ctrl.alu_op2 = id_insn[9:6];
		id_ctrl.comp_op = id_insn[24:21];
		id_ctrl.rf_addrw = id_insn[25:21];
		id_ctrl.spr_read = (op == OP_MFSPR);
		id_ctrl.spr_write = (op == OP_MTSPR);
		// l.sys and l.trap share the XSYNC opcode
		id_ctrl.syscall = (id_insn[31:23] == {OP_XSYNC, 3'b000});
		id_ctrl.trap = (id_insn[31:23] == {OP_XSYNC, 3'b010}) || du_hwbkpt;
		// 26-bit word offset, pc relative
		id_ctrl.branch_target = {{4{id_insn[25]}}, id_insn[25:0]} + id_pc[31:2];
		// zero extension unless overridden below
		id_ctrl.simm = {16'b0, id_insn[15:0]};

		case (op)
			OP_J, OP_JR, OP_BNF, OP_BF, OP_RFE, OP_XSYNC, OP_NOP:
				id_ctrl.illegal = 1'b0;
			OP_JAL, OP_JALR: begin
				id_ctrl.rfwb_op = '{src: RFWB_LR, we: 1'b1};
				id_ctrl.rf_addrw = LINK_REG;
			end
			OP_MOVHI: begin
				id_ctrl.alu_op = ALU_MOVHI;
				id_ctrl.rfwb_op = WB_ALU;
			end
			OP_MFSPR:
				id_ctrl.rfwb_op = '{src: RFWB_SPRS, we: 1'b1};
			// spr number split around the rD field
			OP_MTSPR:
				id_ctrl.simm = {16'b0, id_insn[25:21], id_insn[10:0]};
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS: begin
				id_ctrl.simm = sext16;
				id_ctrl.rfwb_op = '{src: RFWB_LSU, we: 1'b1};
			end
			// store offset uses the same split field, signed
			OP_SW, OP_SB, OP_SH:
				id_ctrl.simm = {{16{id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			OP_ADDI, OP_ADDIC, OP_XORI, OP_MULI: begin
				id_ctrl.simm = sext16;
				id_ctrl.rfwb_op = WB_ALU;
				case (op)
					OP_ADDI:  id_ctrl.alu_op = ALU_ADD;
					OP_ADDIC: id_ctrl.alu_op = ALU_ADDC;
					OP_XORI:  id_ctrl.alu_op = ALU_XOR;
					default:  id_ctrl.alu_op = ALU_MUL;
				endcase
				id_ctrl.illegal = (op == OP_MULI) && !IMPL_MUL;
			end
			OP_ANDI, OP_ORI, OP_SH_ROTI: begin
				id_ctrl.rfwb_op = WB_ALU;
				case (op)
					OP_ANDI: id_ctrl.alu_op = ALU_AND;
					OP_ORI:  id_ctrl.alu_op = ALU_OR;
					default: id_ctrl.alu_op = ALU_SHROT;
				endcase
			end
			OP_SFXXI: begin
				id_ctrl.simm = sext16;
				id_ctrl.alu_op = ALU_COMP;
			end
			OP_SFXX:
				id_ctrl.alu_op = ALU_COMP;
			OP_ALU: begin
				id_ctrl.alu_op = alu_op_e'({1'b0, id_insn[3:0]});
				id_ctrl.rfwb_op = WB_ALU;
				// no divider, multiplier optional
				id_ctrl.illegal = div_fn || (mul_fn && !IMPL_MUL);
			end
			// mac, fpu, custom and undefined opcodes
			default:
				id_ctrl.illegal = 1'b1;
		endcase
	end

	// lsu op goes out straight from ID
	always_comb begin
		case (op)
			OP_LWZ:  id_lsu_op = LSU_LWZ;
			OP_LWS:  id_lsu_op = LSU_LWS;
			OP_LBZ:  id_lsu_op = LSU_LBZ;
			OP_LBS:  id_lsu_op = LSU_LBS;
			OP_LHZ:  id_lsu_op = LSU_LHZ;
			OP_LHS:  id_lsu_op = LSU_LHS;
			OP_SW:   id_lsu_op = LSU_SW;
			OP_SB:   id_lsu_op = LSU_SB;
			OP_SH:   id_lsu_op = LSU_SH;
			default: id_lsu_op = LSU_NOP;
		endcase
	end

endmodule

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ns

module id_stage (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [31:0]           if_insn,
	input  logic                  id_freeze,
	input  logic                  except_flushpipe,
	input  logic                  extend_flush,
	input  logic                  pc_we,
	input  logic                  du_flush_pipe,
	output logic                  flushpipe,
	output logic [31:0]           id_insn,
	output ctrl_pkg::branch_op_e  id_branch_op,
	output logic                  sel_imm,
	output ctrl_pkg::reg_addr_t   rf_addra,
	output ctrl_pkg::reg_addr_t   rf_addrb,
	output logic                  rf_rda,
	output logic                  rf_rdb
);
	import ctrl_pkg::*;

	logic if_sel_imm;

	// any redirect or exception empties the front of the pipe
	assign flushpipe = except_flushpipe | extend_flush | pc_we | du_flush_pipe;

	// register file is read from the fetched word, data lands in ID
	assign rf_addra = if_insn[20:16];
	assign rf_addrb = if_insn[15:11];
	assign rf_rda = if_insn[31];
	assign rf_rdb = if_insn[30];

	// operand b from the immediate field
	always_comb begin
		case (if_insn[31:26])
			OP_JALR, OP_JR, OP_RFE, OP_MFSPR, OP_MTSPR, OP_XSYNC,
			OP_SW, OP_SB, OP_SH, OP_ALU, OP_SFXX, OP_NOP:
				if_sel_imm = 1'b0;
			default:
				if_sel_imm = 1'b1;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// IF -> ID latch

	always_ff @(posedge clk) begin
		if (rst || flushpipe) begin
			id_insn <= NOP_INSN;
			id_branch_op <= BR_NOP;
			sel_imm <= 1'b0;
		end else if (!id_freeze) begin
			id_insn <= if_insn;
			// branch op predecoded here, ready for EX one cycle early
			id_branch_op <= branch_op_of(if_insn);
			sel_imm <= if_sel_imm;
		end
	end

	// flushed ID slot carries a void nop and no branch
	assert property (@(posedge clk) disable iff (rst)
		flushpipe |=> (id_insn == NOP_INSN) && (id_branch_op == BR_NOP) && !sel_imm);

endmodule

// ==== verilog/ctrl_pkg.sv ====
package ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// instruction encodings

	// major opcode, insn[31:26]
	typedef enum logic [5:0] {
		OP_J       = 6'h00,
		OP_JAL     = 6'h01,
		OP_BNF     = 6'h03,
		OP_BF      = 6'h04,
		OP_NOP     = 6'h05,
		OP_MOVHI   = 6'h06,
		OP_XSYNC   = 6'h08,
		OP_RFE     = 6'h09,
		OP_JR      = 6'h11,
		OP_JALR    = 6'h12,
		OP_LWZ     = 6'h21,
		OP_LWS     = 6'h22,
		OP_LBZ     = 6'h23,
		OP_LBS     = 6'h24,
		OP_LHZ     = 6'h25,
		OP_LHS     = 6'h26,
		OP_ADDI    = 6'h27,
		OP_ADDIC   = 6'h28,
		OP_ANDI    = 6'h29,
		OP_ORI     = 6'h2a,
		OP_XORI    = 6'h2b,
		OP_MULI    = 6'h2c,
		OP_MFSPR   = 6'h2d,
		OP_SH_ROTI = 6'h2e,
		OP_SFXXI   = 6'h2f,
		OP_MTSPR   = 6'h30,
		OP_SW      = 6'h35,
		OP_SB      = 6'h36,
		OP_SH      = 6'h37,
		OP_ALU     = 6'h38,
		OP_SFXX    = 6'h39
	} opcode_e;

	typedef enum logic [2:0] {
		BR_NOP = 3'd0,
		BR_J   = 3'd1,
		BR_JR  = 3'd2,
		BR_BNF = 3'd3,
		BR_BF  = 3'd4,
		BR_RFE = 3'd5
	} branch_op_e;

	// alu op, low nibble matches the ALU function field
	typedef enum logic [4:0] {
		ALU_ADD   = 5'd0,
		ALU_ADDC  = 5'd1,
		ALU_SUB   = 5'd2,
		ALU_AND   = 5'd3,
		ALU_OR    = 5'd4,
		ALU_XOR   = 5'd5,
		ALU_MUL   = 5'd6,
		ALU_SHROT = 5'd8,
		ALU_DIV   = 5'd9,
		ALU_DIVU  = 5'd10,
		ALU_MULU  = 5'd11,
		ALU_MOVHI = 5'd12,
		ALU_COMP  = 5'd13,
		ALU_NOP   = 5'd15
	} alu_op_e;

	// write-back source mux
	typedef enum logic [2:0] {
		RFWB_ALU  = 3'd0,
		RFWB_LR   = 3'd1,
		RFWB_SPRS = 3'd2,
		RFWB_LSU  = 3'd3
	} rfwb_src_e;

	typedef struct packed {
		rfwb_src_e src;
		logic      we;
	} rfwb_op_t;

	typedef enum logic [3:0] {
		LSU_NOP = 4'd0,
		LSU_LBZ = 4'd2,
		LSU_LBS = 4'd3,
		LSU_LHZ = 4'd4,
		LSU_LHS = 4'd5,
		LSU_LWZ = 4'd6,
		LSU_LWS = 4'd7,
		LSU_SB  = 4'd8,
		LSU_SH  = 4'd10,
		LSU_SW  = 4'd12
	} lsu_op_e;

	// operand source select
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_e;

	localparam int REG_ADDR_W = 5;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// r9 holds the return address
	localparam reg_addr_t LINK_REG = 5'd9;

	// bubble word, NOP opcode with bit 16 set
	localparam logic [31:0] NOP_INSN = 32'h1541_0000;

	////////////////////////////////////////////////////////////////////////////
	// stage payloads

	typedef struct packed {
		logic [31:0] insn;
		branch_op_e  branch_op;
		alu_op_e     alu_op;
		logic [3:0]  alu_op2;
		logic [3:0]  comp_op;
		rfwb_op_t    rfwb_op;
		reg_addr_t   rf_addrw;
		logic        spr_read;
		logic        spr_write;
		logic        illegal;
		logic        syscall;
		logic        trap;
		logic [31:0] simm;
		logic [31:2] branch_target;
	} ex_ctrl_t;

	localparam ex_ctrl_t EX_BUBBLE = '{
		insn:      NOP_INSN,
		branch_op: BR_NOP,
		alu_op:    ALU_NOP,
		rfwb_op:   '{src: RFWB_ALU, we: 1'b0},
		default:   '0
	};

	typedef struct packed {
		logic [31:0] insn;
		reg_addr_t   rf_addrw;
	} wb_ctrl_t;

	localparam wb_ctrl_t WB_RESET = '{insn: NOP_INSN, rf_addrw: '0};

	////////////////////////////////////////////////////////////////////////////
	// helpers shared by the IF and ID decoders

	function automatic branch_op_e branch_op_of(logic [31:0] insn);
		case (insn[31:26])
			OP_J, OP_JAL:   return BR_J;
			OP_JR, OP_JALR: return BR_JR;
			OP_BNF:         return BR_BNF;
			OP_BF:          return BR_BF;
			OP_RFE:         return BR_RFE;
			default:        return BR_NOP;
		endcase
	endfunction

	// filler nop, marks a void slot
	function automatic logic is_void(logic [31:0] insn);
		return (insn[31:26] == OP_NOP) && insn[16];
	endfunction

endpackage
